/* filelist.f */
common/s1c88_pkg.sv
control/microcode_rom.sv
control/bus_sequencer.sv
src/datapath.sv
src/s1c88.sv
testbench/tb_memory.sv
testbench/tb_s1c88.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log \
    && verilator --binary --timing --assert -j 0 --top-module tb_s1c88 \
        -f filelist.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/tb_s1c88.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_s1c88 import s1c88_pkg::*; ();

    localparam int NUM_INSTR = 24;
    localparam int RESET_CLOCKS = 4;
    localparam int MARGIN_CLOCKS = 100;
    localparam int HALF_PERIOD = 20;

    // one strobe cycle the core is expected to run
    typedef struct packed {
        logic              is_write;
        logic              sync;
        logic              iack;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [7:0]        test;
    } access_t;

    logic              clk;
    logic              reset;
    logic [DATA_W-1:0] data_in;
    logic [DATA_W-1:0] data_out;
    logic [ADDR_W-1:0] address_out;
    bus_status_e       bus_status;
    logic              read;
    logic              write;
    logic              sync;
    logic              iack;

    integer            seed;
    int                cycle_count = 0;
    int                cycle_limit;
    int                release_cycle;
    int                shape_errors = 0;
    int                access_errors = 0;
    int                test_err_base = 0;
    int                pass_count = 0;
    int                fail_count = 0;
    logic [7:0]        cur_test = 8'd0;
    logic              seen_first = 1'b0;
    logic              done = 1'b0;
    access_t           expected [$];
    string             test_name [0:NUM_INSTR];
    logic [DATA_W-1:0] ref_mem [0:65535];

    s1c88 UUT (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .data_out    (data_out),
        .address_out (address_out),
        .bus_status  (bus_status),
        .read        (read),
        .write       (write),
        .sync        (sync),
        .iack        (iack)
    );

    tb_memory u_memory (
        .clk        (clk),
        .address    (address_out),
        .read       (read),
        .write      (write),
        .write_data (data_out),
        .read_data  (data_in)
    );

    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout after %0d clocks, %0d bus cycles never happened",
                     cycle_count, expected.size());
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    reset_quiet: assert property (@(posedge clk)
        reset |-> !read && !write && !sync && !iack && bus_status == BUS_IDLE
                  && address_out == IDLE_ADDRESS && data_out == 8'hFF)
    else
    begin
        shape_errors = shape_errors + 1;
        $display("bus outputs not idle during reset at %0t", $time);
    end

    // the idle clocks between reset release and the vector read
    wait_quiet: assert property (@(posedge clk) disable iff (reset)
        (cycle_count - release_cycle < RESET_WAIT_CYCLES)
        |-> !read && !write && !sync && !iack && address_out == IDLE_ADDRESS)
    else
    begin
        shape_errors = shape_errors + 1;
        $display("bus outputs not idle during the reset wait at %0t", $time);
    end

    strobe_single: assert property (@(posedge clk) disable iff (reset)
        (read || write) |=> !(read || write))
    else
    begin
        shape_errors = shape_errors + 1;
        $display("read or write strobe longer than one clock at %0t", $time);
    end

    // address and cycle marks set up in the first clock and held in the second
    cycle_held: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> address_out == $past(address_out)
                            && sync == $past(sync) && iack == $past(iack))
    else
    begin
        shape_errors = shape_errors + 1;
        $display("address, sync or iack changed inside a bus cycle at %0t", $time);
    end

    status_match: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> bus_status == (write ? BUS_MEM_WRITE : BUS_MEM_READ))
    else
    begin
        shape_errors = shape_errors + 1;
        $display("bus_status does not match the strobe at %0t", $time);
    end

    page_zero: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> address_out[ADDR_W-1:PC_W] == '0)
    else
    begin
        shape_errors = shape_errors + 1;
        $display("upper address byte not zero during a bus cycle at %0t", $time);
    end

    // every address bit takes part in the pattern
    function automatic logic [DATA_W-1:0] fill_byte(input logic [PC_W-1:0] addr);
        return addr[7:0] ^ {addr[11:8], addr[15:12]} ^ 8'hA5;
    endfunction

    task automatic put_byte(input logic [PC_W-1:0] addr, input logic [DATA_W-1:0] value);
        u_memory.mem[addr] = value;
        ref_mem[addr] = value;
    endtask

    task automatic expect_access(input logic is_write, input logic sync_exp,
                                 input logic iack_exp, input logic [PC_W-1:0] addr,
                                 input logic [DATA_W-1:0] data, input int test);
        access_t item;
        item.is_write = is_write;
        item.sync = sync_exp;
        item.iack = iack_exp;
        item.addr = {{(ADDR_W - PC_W){1'b0}}, addr};
        item.data = data;
        item.test = 8'(test);
        expected.push_back(item);
    endtask

    // random program plus the bus cycles it must produce
    task automatic build_program();
        logic [PC_W-1:0]   vector;
        logic [PC_W-1:0]   pc;
        logic [PC_W-1:0]   ptr;
        logic [DATA_W-1:0] br;
        logic [DATA_W-1:0] op;
        logic [DATA_W-1:0] ll;
        logic [DATA_W-1:0] nn;
        logic [DATA_W-1:0] result;
        integer            rnd;
        int                kind;
        int                bus_cycles;
        int                a;
        int                i;

        for (a = 0; a < 65536; a++)
            put_byte(a[PC_W-1:0], fill_byte(a[PC_W-1:0]));

        rnd = $random(seed);
        vector = {4'h1, rnd[11:4], 4'h0};
        put_byte(16'h0000, vector[7:0]);
        put_byte(16'h0001, vector[15:8]);
        expect_access(1'b0, 1'b0, 1'b1, 16'h0000, vector[7:0], 0);
        expect_access(1'b0, 1'b0, 1'b1, 16'h0001, vector[15:8], 0);
        test_name[0] = "reset entry";
        bus_cycles = 2;
        pc = vector;
        br = 8'h00;

        for (i = 1; i <= NUM_INSTR; i++)
        begin
            rnd = $random(seed);
            // the first six instructions run every kind once, LD BR first
            kind = (i <= 6) ? i % 6 : int'(rnd[15:0]) % 6;
            ll = rnd[23:16];
            nn = rnd[31:24];
            ptr = {br, ll};
            if (kind == 0)
            begin
                op = nn;
                if (op inside {8'hB4, 8'hD8, 8'hD9, 8'hDA, 8'hDD})
                    op = 8'h00;
                put_byte(pc, op);
                expect_access(1'b0, 1'b1, 1'b0, pc, op, i);
                test_name[i] = "no-op";
                pc = pc + 16'd1;
                bus_cycles = bus_cycles + 2;
            end
            else if (kind == 1)
            begin
                // data pages stay above the code and the vector
                br = {1'b1, ll[6:0]};
                put_byte(pc, 8'hB4);
                put_byte(pc + 16'd1, br);
                expect_access(1'b0, 1'b1, 1'b0, pc, 8'hB4, i);
                expect_access(1'b0, 1'b0, 1'b0, pc + 16'd1, br, i);
                test_name[i] = "LD BR,#nn";
                pc = pc + 16'd2;
                bus_cycles = bus_cycles + 3;
            end
            else
            begin
                op = (kind == 2) ? 8'hDD : 8'hD8 + 8'(kind - 3);
                put_byte(pc, op);
                put_byte(pc + 16'd1, ll);
                put_byte(pc + 16'd2, nn);
                expect_access(1'b0, 1'b1, 1'b0, pc, op, i);
                expect_access(1'b0, 1'b0, 1'b0, pc + 16'd1, ll, i);
                expect_access(1'b0, 1'b0, 1'b0, pc + 16'd2, nn, i);
                if (kind == 2)
                begin
                    result = nn;
                    test_name[i] = "LD [BR:ll],#nn";
                    bus_cycles = bus_cycles + 4;
                end
                else
                begin
                    expect_access(1'b0, 1'b0, 1'b0, ptr, ref_mem[ptr], i);
                    case (kind)
                        3:
                        begin
                            result = ref_mem[ptr] & nn;
                            test_name[i] = "AND [BR:ll],#nn";
                        end
                        4:
                        begin
                            result = ref_mem[ptr] | nn;
                            test_name[i] = "OR [BR:ll],#nn";
                        end
                        default:
                        begin
                            result = ref_mem[ptr] ^ nn;
                            test_name[i] = "XOR [BR:ll],#nn";
                        end
                    endcase
                    bus_cycles = bus_cycles + 5;
                end
                expect_access(1'b1, 1'b0, 1'b0, ptr, result, i);
                ref_mem[ptr] = result;
                pc = pc + 16'd3;
            end
        end

        // the next fetch shows the length of the last instruction
        expect_access(1'b0, 1'b1, 1'b0, pc, ref_mem[pc], NUM_INSTR);
        bus_cycles = bus_cycles + 1;
        cycle_limit = RESET_CLOCKS + RESET_WAIT_CYCLES + bus_cycles * 2 + MARGIN_CLOCKS;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        access_errors = access_errors + 1;
        $display("ERR %0t %s expected %0h got %0h", $time, name, want, got);
    endtask

    task automatic close_test(input logic [7:0] next_test);
        int errors;
        errors = shape_errors + access_errors;
        if (errors == test_err_base)
        begin
            pass_count = pass_count + 1;
            $display("test %0d %s ok", cur_test, test_name[cur_test]);
        end
        else
        begin
            fail_count = fail_count + 1;
            $display("test %0d %s failed with %0d errors", cur_test, test_name[cur_test],
                     errors - test_err_base);
        end
        test_err_base = errors;
        cur_test = next_test;
    endtask

    task automatic check_access();
        access_t item;
        if (expected.size() == 0)
        begin
            access_errors = access_errors + 1;
            $display("bus cycle at %0t after the program ran out", $time);
        end
        else
        begin
            item = expected.pop_front();
            if (!seen_first)
            begin
                seen_first = 1'b1;
                assert (cycle_count - release_cycle == RESET_WAIT_CYCLES + 1)
                else
                begin
                    access_errors = access_errors + 1;
                    $display("first bus cycle did not follow the reset wait at %0t", $time);
                end
            end
            if (item.test != cur_test)
                close_test(item.test);
            assert (read == !item.is_write)
                else report_mismatch("read", 32'(!item.is_write), 32'(read));
            assert (write == item.is_write)
                else report_mismatch("write", 32'(item.is_write), 32'(write));
            assert (address_out == item.addr)
                else report_mismatch("address_out", 32'(item.addr), 32'(address_out));
            assert (sync == item.sync)
                else report_mismatch("sync", 32'(item.sync), 32'(sync));
            assert (iack == item.iack)
                else report_mismatch("iack", 32'(item.iack), 32'(iack));
            if (item.is_write)
            begin
                assert (data_out == item.data)
                    else report_mismatch("data_out", 32'(item.data), 32'(data_out));
            end
            if (expected.size() == 0)
            begin
                close_test(8'(NUM_INSTR + 1));
                done = 1'b1;
            end
        end
    endtask

    // strobes are looked at in the middle of their clock
    always @(negedge clk)
    begin
        if (!reset && (read || write))
            check_access();
    end

    initial
    begin
        seed = 32'h4956172e;
        clk = 1'b0;
        reset = 1'b1;
        build_program();
        repeat (RESET_CLOCKS) @(negedge clk);
        reset = 1'b0;
        release_cycle = cycle_count;
        wait (done);
        @(posedge clk);
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 pass_count, fail_count, shape_errors + access_errors);
        if (shape_errors + access_errors == 0 && pass_count == NUM_INSTR + 1)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_memory import s1c88_pkg::*; (
    input  logic              clk,
    input  logic [ADDR_W-1:0] address,
    input  logic              read,
    input  logic              write,
    input  logic [DATA_W-1:0] write_data,
    output logic [DATA_W-1:0] read_data
);

    // only the low 16 address bits reach the array
    logic [DATA_W-1:0] mem [0:65535];

    initial
    begin
        read_data = '1;
    end

    // read data changes halfway through the strobe clock
    always @(negedge clk)
    begin
        if (read)
            read_data = mem[address[PC_W-1:0]];
        else
            read_data = '1;
    end

    always @(posedge clk)
    begin
        if (write)
            mem[address[PC_W-1:0]] = write_data;
    end

endmodule

`default_nettype wire

/* src/s1c88.sv */
`timescale 1ns/10ps
`default_nettype none

module s1c88 import s1c88_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [DATA_W-1:0]  data_in,
    output logic [DATA_W-1:0]  data_out,
    output logic [ADDR_W-1:0]  address_out,
    output bus_status_e        bus_status,
    output logic               read,
    output logic               write,
    output logic               sync,
    output logic               iack
);

    logic [DATA_W-1:0]       opcode;
    logic [MICRO_ADDR_W-1:0] micro_addr;
    logic [PC_W-1:0]         data_ptr;
    decode_entry_t           decode;
    micro_op_t               micro_op;
    dp_ctrl_t                ctrl;

    bus_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .data_in     (data_in),
        .decode      (decode),
        .micro_op    (micro_op),
        .data_ptr    (data_ptr),
        .opcode      (opcode),
        .micro_addr  (micro_addr),
        .ctrl        (ctrl),
        .address_out (address_out),
        .bus_status  (bus_status),
        .read        (read),
        .write       (write),
        .sync        (sync),
        .iack        (iack)
    );

    microcode_rom u_rom (
        .opcode     (opcode),
        .micro_addr (micro_addr),
        .decode     (decode),
        .micro_op   (micro_op)
    );

    datapath u_datapath (
        .clk      (clk),
        .reset    (reset),
        .data_in  (data_in),
        .ctrl     (ctrl),
        .data_ptr (data_ptr),
        .data_out (data_out)
    );

endmodule

`default_nettype wire

/* src/datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath import s1c88_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [DATA_W-1:0] data_in,
    input  dp_ctrl_t          ctrl,
    output logic [PC_W-1:0]   data_ptr,
    output logic [DATA_W-1:0] data_out
);

    logic [DATA_W-1:0] imm_low;
    logic [DATA_W-1:0] imm_high;
    logic [DATA_W-1:0] br;
    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_r;
    logic [DATA_W-1:0] wr_data;

    // [BR:ll] addressing, page register over the low immediate
    assign data_ptr = {br, imm_low};

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_AND:
                alu_r = alu_a & imm_high;
            ALU_OR:
                alu_r = alu_a | imm_high;
            ALU_XOR:
                alu_r = alu_a ^ imm_high;
            default:
                alu_r = alu_a;
        endcase
    end

    assign wr_data = (ctrl.wr_src == SRC_ALU_R) ? alu_r : imm_high;

    // operand bytes straight off the bus
    always_ff @(posedge clk)
    begin
        if (ctrl.load_imm_low)
            imm_low <= data_in;
        if (ctrl.load_imm_high)
            imm_high <= data_in;
        if (ctrl.load_alu_a)
            alu_a <= data_in;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            br <= '0;
            data_out <= '1;
        end
        else
        begin
            // LD BR,#nn takes its byte from the low immediate
            if (ctrl.load_br)
                br <= imm_low;
            if (ctrl.load_data_out)
                data_out <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* control/bus_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_sequencer import s1c88_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [DATA_W-1:0]       data_in,
    input  decode_entry_t           decode,
    input  micro_op_t               micro_op,
    input  logic [PC_W-1:0]         data_ptr,
    output logic [DATA_W-1:0]       opcode,
    output logic [MICRO_ADDR_W-1:0] micro_addr,
    output dp_ctrl_t                ctrl,
    output logic [ADDR_W-1:0]       address_out,
    output bus_status_e             bus_status,
    output logic                    read,
    output logic                    write,
    output logic                    sync,
    output logic                    iack
);

    cpu_state_e              state;
    logic [1:0]              wait_count;
    logic                    phase;
    logic [PC_W-1:0]         pc;
    logic [DATA_W-1:0]       opcode_q;
    logic [MICRO_ADDR_W-1:0] micro_step;
    logic                    exec_read;
    logic                    exec_write;
    logic                    exec_misc;

    // the translation table sees the byte on the bus while it is fetched
    assign opcode = (state == STATE_FETCH) ? data_in : opcode_q;
    assign micro_addr = micro_step;

    assign exec_read = (state == STATE_EXECUTE) && (micro_op.kind == MICRO_BUS_READ);
    assign exec_write = (state == STATE_EXECUTE) && (micro_op.kind == MICRO_BUS_WRITE);
    assign exec_misc = (state == STATE_EXECUTE) && (micro_op.kind == MICRO_MISC);

    // phase 0 puts out the address, phase 1 carries the strobe
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= STATE_RESET_WAIT;
            wait_count <= '0;
            phase <= 1'b0;
            micro_step <= UADDR_NOP;
        end
        else if (state == STATE_RESET_WAIT)
        begin
            if (wait_count == 2'(RESET_WAIT_CYCLES - 1))
                state <= STATE_VECTOR_LOW;
            else
                wait_count <= wait_count + 1'b1;
        end
        else if (!phase)
        begin
            phase <= 1'b1;
        end
        else
        begin
            phase <= 1'b0;
            case (state)
                STATE_VECTOR_LOW:
                    state <= STATE_VECTOR_HIGH;
                STATE_VECTOR_HIGH:
                    state <= STATE_FETCH;
                STATE_FETCH:
                begin
                    micro_step <= decode.start;
                    state <= (decode.imm_count == 2'd0) ? STATE_EXECUTE : STATE_IMM_LOW;
                end
                STATE_IMM_LOW:
                    state <= (decode.imm_count == 2'd2) ? STATE_IMM_HIGH : STATE_EXECUTE;
                STATE_IMM_HIGH:
                    state <= STATE_EXECUTE;
                STATE_EXECUTE:
                begin
                    if (micro_op.last)
                        state <= STATE_FETCH;
                    else
                        micro_step <= micro_step + 1'b1;
                end
                default:
                    state <= STATE_RESET_WAIT;
            endcase
        end
    end

    // PC and opcode only change at the end of a read cycle
    always_ff @(posedge clk)
    begin
        if (phase)
        begin
            case (state)
                STATE_VECTOR_LOW:
                    pc[DATA_W-1:0] <= data_in;
                STATE_VECTOR_HIGH:
                    pc[PC_W-1:DATA_W] <= data_in;
                STATE_FETCH:
                begin
                    opcode_q <= data_in;
                    pc <= pc + 1'b1;
                end
                STATE_IMM_LOW, STATE_IMM_HIGH:
                    pc <= pc + 1'b1;
                default:
                    pc <= pc;
            endcase
        end
    end

    always_comb
    begin
        ctrl.load_imm_low = phase && (state == STATE_IMM_LOW);
        ctrl.load_imm_high = phase && (state == STATE_IMM_HIGH);
        ctrl.load_br = phase && exec_misc && (micro_op.dst == DST_BR);
        ctrl.load_alu_a = phase && exec_read && (micro_op.dst == DST_ALU_A);
        // write data must be ready for the strobe clock
        ctrl.load_data_out = !phase && exec_write;
        ctrl.alu_op = micro_op.alu_op;
        ctrl.wr_src = micro_op.src;
    end

    always_comb
    begin
        address_out = {{(ADDR_W - PC_W){1'b0}}, pc};
        bus_status = BUS_MEM_READ;
        case (state)
            STATE_RESET_WAIT:
            begin
                address_out = IDLE_ADDRESS;
                bus_status = BUS_IDLE;
            end
            STATE_VECTOR_LOW:
                address_out = RESET_VECTOR_ADDR;
            STATE_VECTOR_HIGH:
                address_out = RESET_VECTOR_ADDR + ADDR_W'(1);
            STATE_EXECUTE:
            begin
                address_out = {{(ADDR_W - PC_W){1'b0}}, data_ptr};
                if (exec_write)
                    bus_status = BUS_MEM_WRITE;
                else if (exec_misc)
                    bus_status = BUS_IDLE;
            end
            default:
                bus_status = BUS_MEM_READ;
        endcase

        read = phase && (state != STATE_RESET_WAIT) && (state != STATE_EXECUTE || exec_read);
        write = phase && exec_write;
        sync = (state == STATE_FETCH);
        iack = (state == STATE_VECTOR_LOW) || (state == STATE_VECTOR_HIGH);
    end

endmodule

`default_nettype wire

/* control/microcode_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module microcode_rom import s1c88_pkg::*; (
    input  logic [DATA_W-1:0]       opcode,
    input  logic [MICRO_ADDR_W-1:0] micro_addr,
    output decode_entry_t           decode,
    output micro_op_t               micro_op
);

    // translation table, unknown opcodes land on the no-op entry
    always_comb
    begin
        case (opcode)
            OP_LD_BR_IMM:
                decode = '{start: UADDR_LD_BR, imm_count: 2'd1};
            OP_LD_BR_IND_IMM:
                decode = '{start: UADDR_ST_IMM, imm_count: 2'd2};
            OP_AND_BR_IMM:
                decode = '{start: UADDR_AND, imm_count: 2'd2};
            OP_OR_BR_IMM:
                decode = '{start: UADDR_OR, imm_count: 2'd2};
            OP_XOR_BR_IMM:
                decode = '{start: UADDR_XOR, imm_count: 2'd2};
            default:
                decode = '{start: UADDR_NOP, imm_count: 2'd0};
        endcase
    end

    // microword fields are kind, alu op, destination, write source, last
    always_comb
    begin
        case (micro_addr)
            UADDR_LD_BR:
                micro_op = '{MICRO_MISC, ALU_PASS, DST_BR, SRC_IMM_HIGH, 1'b1};
            UADDR_ST_IMM:
                micro_op = '{MICRO_BUS_WRITE, ALU_PASS, DST_NONE, SRC_IMM_HIGH, 1'b1};

            // read [BR:ll] into the ALU, then write back the result
            UADDR_AND:
                micro_op = '{MICRO_BUS_READ, ALU_AND, DST_ALU_A, SRC_ALU_R, 1'b0};
            UADDR_AND + 5'd1:
                micro_op = '{MICRO_BUS_WRITE, ALU_AND, DST_NONE, SRC_ALU_R, 1'b1};
            UADDR_OR:
                micro_op = '{MICRO_BUS_READ, ALU_OR, DST_ALU_A, SRC_ALU_R, 1'b0};
            UADDR_OR + 5'd1:
                micro_op = '{MICRO_BUS_WRITE, ALU_OR, DST_NONE, SRC_ALU_R, 1'b1};
            UADDR_XOR:
                micro_op = '{MICRO_BUS_READ, ALU_XOR, DST_ALU_A, SRC_ALU_R, 1'b0};
            UADDR_XOR + 5'd1:
                micro_op = '{MICRO_BUS_WRITE, ALU_XOR, DST_NONE, SRC_ALU_R, 1'b1};

            // entry 0 and the empty rows end the instruction at once
            default:
                micro_op = '{MICRO_MISC, ALU_PASS, DST_NONE, SRC_IMM_HIGH, 1'b1};
        endcase
    end

endmodule

`default_nettype wire

/* common/s1c88_pkg.sv */
`default_nettype none

package s1c88_pkg;

    // bus and register widths
    localparam int ADDR_W = 24;
    localparam int DATA_W = 8;
    localparam int PC_W = 16;
    localparam int MICRO_ADDR_W = 5;

    // reset entry
    localparam logic [ADDR_W-1:0] RESET_VECTOR_ADDR = '0;
    localparam int RESET_WAIT_CYCLES = 2;
    localparam logic [ADDR_W-1:0] IDLE_ADDRESS = '1;

    // microcode entry points, logic ops use two consecutive words
    localparam logic [MICRO_ADDR_W-1:0] UADDR_NOP = 5'd0;
    localparam logic [MICRO_ADDR_W-1:0] UADDR_LD_BR = 5'd1;
    localparam logic [MICRO_ADDR_W-1:0] UADDR_ST_IMM = 5'd2;
    localparam logic [MICRO_ADDR_W-1:0] UADDR_AND = 5'd3;
    localparam logic [MICRO_ADDR_W-1:0] UADDR_OR = 5'd5;
    localparam logic [MICRO_ADDR_W-1:0] UADDR_XOR = 5'd7;

    typedef enum logic [2:0] {
        STATE_RESET_WAIT,
        STATE_VECTOR_LOW,
        STATE_VECTOR_HIGH,
        STATE_FETCH,
        STATE_IMM_LOW,
        STATE_IMM_HIGH,
        STATE_EXECUTE
    } cpu_state_e;

    typedef enum logic [1:0] {
        BUS_IDLE      = 2'd0,
        BUS_IRQ_READ  = 2'd1,
        BUS_MEM_WRITE = 2'd2,
        BUS_MEM_READ  = 2'd3
    } bus_status_e;

    typedef enum logic [7:0] {
        OP_LD_BR_IMM     = 8'hB4,
        OP_AND_BR_IMM    = 8'hD8,
        OP_OR_BR_IMM     = 8'hD9,
        OP_XOR_BR_IMM    = 8'hDA,
        OP_LD_BR_IND_IMM = 8'hDD
    } opcode_e;

    typedef enum logic [1:0] {MICRO_MISC, MICRO_BUS_READ, MICRO_BUS_WRITE} micro_kind_e;
    typedef enum logic [1:0] {ALU_PASS, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;
    typedef enum logic [1:0] {DST_NONE, DST_BR, DST_ALU_A} micro_dst_e;
    typedef enum logic {SRC_IMM_HIGH, SRC_ALU_R} micro_src_e;

    typedef struct packed {
        micro_kind_e kind;
        alu_op_e     alu_op;
        micro_dst_e  dst;
        micro_src_e  src;
        logic        last;
    } micro_op_t;

    // one entry of the opcode translation table
    typedef struct packed {
        logic [MICRO_ADDR_W-1:0] start;
        logic [1:0]              imm_count;
    } decode_entry_t;

    // datapath strobes, each valid for a single clock
    typedef struct packed {
        logic       load_imm_low;
        logic       load_imm_high;
        logic       load_br;
        logic       load_alu_a;
        logic       load_data_out;
        alu_op_e    alu_op;
        micro_src_e wr_src;
    } dp_ctrl_t;

endpackage

`default_nettype wire
